// ==== dcache.sv ====
`timescale 1ns/100ps
`default_nettype none

module dcache (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_pkg::dmem_req_t         dmem_req_i,
    output logic                       dmem_resp_o,
    output logic [mem_pkg::WORD_W-1:0] dmem_rdata_o,
    output mem_pkg::line_req_t         line_req_o,
    input  mem_pkg::line_rsp_t         line_rsp_i
);

    typedef enum logic [1:0] {S_LOOKUP, S_WBACK, S_FILL} state_t;

    state_t                                       state_q;
    logic                                         resp_q;
    logic [mem_pkg::WORD_W-1:0]                   rdata_q;
    logic [(1 << mem_pkg::INDEX_W)-1:0]           valid_q;
    logic [(1 << mem_pkg::INDEX_W)-1:0]           dirty_q;
    logic [mem_pkg::TAG_W-1:0]                    tag_mem  [1 << mem_pkg::INDEX_W];
    mem_pkg::line_t                               line_mem [1 << mem_pkg::INDEX_W];
    logic [mem_pkg::TAG_W-1:0]                    req_tag;
    logic [mem_pkg::INDEX_W-1:0]                  req_idx;
    logic [$clog2(mem_pkg::WORDS_PER_LINE)-1:0]   req_word;
    logic                                         req_active;
    logic                                         hit;
    logic                                         lookup;
    logic                                         fill_done;
    logic                                         wback_done;
    mem_pkg::line_t                               src_line;
    mem_pkg::line_t                               new_line;
    logic [mem_pkg::WORD_W-1:0]                   new_word;

    assign req_tag    = dmem_req_i.addr[mem_pkg::ADDR_W-1 -: mem_pkg::TAG_W];
    assign req_idx    = dmem_req_i.addr[mem_pkg::OFFSET_W +: mem_pkg::INDEX_W];
    assign req_word   = dmem_req_i.addr[$clog2(mem_pkg::WORD_W/8) +:
                                        $clog2(mem_pkg::WORDS_PER_LINE)];
    assign req_active = dmem_req_i.read || dmem_req_i.write;

    assign hit        = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign lookup     = (state_q == S_LOOKUP) && req_active && !resp_q;
    assign fill_done  = (state_q == S_FILL) && line_rsp_i.resp;
    assign wback_done = (state_q == S_WBACK) && line_rsp_i.resp;

    // store merge works on the cached line or on the line arriving from memory
    always_comb begin
        src_line = (state_q == S_FILL) ? line_rsp_i.rdata : line_mem[req_idx];
        new_word = src_line.words[req_word];
        if (dmem_req_i.write) begin
            for (int b = 0; b < mem_pkg::WORD_W/8; b++) begin
                if (dmem_req_i.wmask[b]) new_word[8*b +: 8] = dmem_req_i.wdata[8*b +: 8];
            end
        end
        new_line                = src_line;
        new_line.words[req_word] = new_word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_LOOKUP;
            resp_q  <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            resp_q <= (lookup && hit) || fill_done;
            case (state_q)
                S_LOOKUP: begin
                    if (lookup && hit && dmem_req_i.write) dirty_q[req_idx] <= 1'b1;
                    if (lookup && !hit) begin
                        // dirty victim goes out first
                        state_q <= (valid_q[req_idx] && dirty_q[req_idx]) ? S_WBACK : S_FILL;
                    end
                end
                S_WBACK: begin
                    if (wback_done) state_q <= S_FILL;
                end
                default: begin
                    if (fill_done) begin
                        state_q          <= S_LOOKUP;
                        valid_q[req_idx] <= 1'b1;
                        dirty_q[req_idx] <= dmem_req_i.write;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((lookup && hit) || fill_done) rdata_q <= new_word;
        if ((lookup && hit && dmem_req_i.write) || fill_done) line_mem[req_idx] <= new_line;
        if (fill_done) tag_mem[req_idx] <= req_tag;
    end

    always_comb begin
        line_req_o       = '0;
        line_req_o.wdata = line_mem[req_idx];
        line_req_o.write = (state_q == S_WBACK);
        line_req_o.read  = (state_q == S_FILL);
        if (state_q == S_WBACK) begin
            line_req_o.addr = {tag_mem[req_idx], req_idx, {mem_pkg::OFFSET_W{1'b0}}};  // victim
        end else begin
            line_req_o.addr = {req_tag, req_idx, {mem_pkg::OFFSET_W{1'b0}}};
        end
    end

    assign dmem_resp_o  = resp_q;
    assign dmem_rdata_o = rdata_q;

    a_no_rd_wr : assert property (@(posedge clk) disable iff (rst)
        !(line_req_o.read && line_req_o.write));

endmodule : dcache

`default_nettype wire

// ==== icache.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_pkg::imem_req_t         imem_req_i,
    output logic                       imem_resp_o,
    output logic [mem_pkg::WORD_W-1:0] imem_rdata_o,
    output mem_pkg::line_req_t         line_req_o,
    input  mem_pkg::line_rsp_t         line_rsp_i
);

    typedef enum logic {S_LOOKUP, S_REFILL} state_t;

    state_t                                       state_q;
    logic                                         resp_q;
    logic [mem_pkg::WORD_W-1:0]                   rdata_q;
    logic [(1 << mem_pkg::INDEX_W)-1:0]           valid_q;
    logic [mem_pkg::TAG_W-1:0]                    tag_mem  [1 << mem_pkg::INDEX_W];
    mem_pkg::line_t                               line_mem [1 << mem_pkg::INDEX_W];
    logic [mem_pkg::TAG_W-1:0]                    req_tag;
    logic [mem_pkg::INDEX_W-1:0]                  req_idx;
    logic [$clog2(mem_pkg::WORDS_PER_LINE)-1:0]   req_word;
    logic                                         hit;
    logic                                         lookup;
    logic                                         refill_done;

    assign req_tag  = imem_req_i.addr[mem_pkg::ADDR_W-1 -: mem_pkg::TAG_W];
    assign req_idx  = imem_req_i.addr[mem_pkg::OFFSET_W +: mem_pkg::INDEX_W];
    assign req_word = imem_req_i.addr[$clog2(mem_pkg::WORD_W/8) +:
                                      $clog2(mem_pkg::WORDS_PER_LINE)];

    assign hit         = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign lookup      = (state_q == S_LOOKUP) && imem_req_i.read && !resp_q;  // skip resp cycle
    assign refill_done = (state_q == S_REFILL) && line_rsp_i.resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_LOOKUP;
            resp_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            resp_q <= (lookup && hit) || refill_done;
            if (lookup && !hit) state_q <= S_REFILL;
            if (refill_done) begin
                state_q          <= S_LOOKUP;
                valid_q[req_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && hit) rdata_q <= line_mem[req_idx].words[req_word];
        if (refill_done) begin
            rdata_q           <= line_rsp_i.rdata.words[req_word];  // forward the new word
            line_mem[req_idx] <= line_rsp_i.rdata;
            tag_mem[req_idx]  <= req_tag;
        end
    end

    always_comb begin
        line_req_o      = '0;
        line_req_o.addr = {req_tag, req_idx, {mem_pkg::OFFSET_W{1'b0}}};
        line_req_o.read = (state_q == S_REFILL);
    end

    assign imem_resp_o  = resp_q;
    assign imem_rdata_o = rdata_q;

    // refill is a pure read, held with a steady address until its resp
    a_refill_held : assert property (@(posedge clk) disable iff (rst)
        (line_req_o.read && !line_rsp_i.resp) |=>
            (line_req_o.read && !line_req_o.write && $stable(line_req_o.addr)));

endmodule : icache

`default_nettype wire

// ==== line_adaptor.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_adaptor (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_pkg::line_req_t         line_req_i,
    output mem_pkg::line_rsp_t         line_rsp_o,
    output logic [mem_pkg::ADDR_W-1:0] bmem_address_o,
    output logic                       bmem_read_o,
    output logic                       bmem_write_o,
    output logic [mem_pkg::BEAT_W-1:0] bmem_wdata_o,
    input  logic [mem_pkg::BEAT_W-1:0] bmem_rdata_i,
    input  logic                       bmem_resp_i
);

    typedef enum logic [1:0] {A_IDLE, A_WRITE, A_READ, A_DONE} state_t;

    state_t                                      state_q;
    logic [$clog2(mem_pkg::BEATS_PER_LINE)-1:0]  beat_q;
    logic [mem_pkg::ADDR_W-1:0]                  addr_q;
    mem_pkg::line_t                              line_q;   // write source or read gather
    logic                                        last_beat;

    assign last_beat = bmem_resp_i &&
        (beat_q == $clog2(mem_pkg::BEATS_PER_LINE)'(mem_pkg::BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= A_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                A_IDLE: begin
                    beat_q <= '0;
                    if (line_req_i.write) state_q <= A_WRITE;
                    else if (line_req_i.read) state_q <= A_READ;
                end
                A_WRITE, A_READ: begin
                    if (bmem_resp_i) beat_q <= beat_q + 1'b1;
                    if (last_beat) state_q <= A_DONE;   // strobe drops here
                end
                default: state_q <= A_IDLE;             // line resp cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == A_IDLE) begin
            addr_q <= line_req_i.addr;
            line_q <= line_req_i.wdata;
        end
        if ((state_q == A_READ) && bmem_resp_i) line_q.beats[beat_q] <= bmem_rdata_i;
    end

    assign bmem_address_o   = addr_q;
    assign bmem_read_o      = (state_q == A_READ);
    assign bmem_write_o     = (state_q == A_WRITE);
    assign bmem_wdata_o     = line_q.beats[beat_q];
    assign line_rsp_o.resp  = (state_q == A_DONE);
    assign line_rsp_o.rdata = line_q;

    // caches must hand over line aligned addresses
    a_bus_strobe : assert property (@(posedge clk) disable iff (rst)
        (bmem_read_o || bmem_write_o) |->
            (!(bmem_read_o && bmem_write_o) && (bmem_address_o[mem_pkg::OFFSET_W-1:0] == '0)));

endmodule : line_adaptor

`default_nettype wire

// ==== line_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::line_req_t i_req_i,
    input  mem_pkg::line_req_t d_req_i,
    output mem_pkg::line_rsp_t i_rsp_o,
    output mem_pkg::line_rsp_t d_rsp_o,
    output mem_pkg::line_req_t mem_req_o,
    input  mem_pkg::line_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {G_IDLE, G_INST, G_DATA} grant_t;

    grant_t grant_q;
    logic   i_pending;
    logic   d_pending;

    assign i_pending = i_req_i.read || i_req_i.write;
    assign d_pending = d_req_i.read || d_req_i.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= G_IDLE;
        end else begin
            case (grant_q)
                G_IDLE: begin
                    if (d_pending) grant_q <= G_DATA;       // data wins ties
                    else if (i_pending) grant_q <= G_INST;
                end
                default: begin
                    if (mem_rsp_i.resp) grant_q <= G_IDLE;  // one idle cycle between grants
                end
            endcase
        end
    end

    always_comb begin
        mem_req_o     = '0;
        i_rsp_o       = '0;
        d_rsp_o       = '0;
        i_rsp_o.rdata = mem_rsp_i.rdata;
        d_rsp_o.rdata = mem_rsp_i.rdata;
        case (grant_q)
            G_INST: begin
                mem_req_o    = i_req_i;
                i_rsp_o.resp = mem_rsp_i.resp;
            end
            G_DATA: begin
                mem_req_o    = d_req_i;
                d_rsp_o.resp = mem_rsp_i.resp;
            end
            default: mem_req_o = '0;
        endcase
    end

    // each adaptor resp lands on exactly one cache
    a_one_side : assert property (@(posedge clk) disable iff (rst)
        mem_rsp_i.resp |-> (i_rsp_o.resp ^ d_rsp_o.resp));

endmodule : line_arbiter

`default_nettype wire

// ==== mem_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_pkg::imem_req_t         imem_req_i,
    input  logic                       imem_resp_i,
    input  logic [mem_pkg::WORD_W-1:0] imem_rdata_i,
    input  mem_pkg::dmem_req_t         dmem_req_i,
    input  logic                       dmem_resp_i,
    input  logic [mem_pkg::WORD_W-1:0] dmem_rdata_i,
    input  logic [mem_pkg::ADDR_W-1:0] bmem_address_i,
    input  logic                       bmem_read_i,
    input  logic                       bmem_write_i,
    input  logic                       bmem_resp_i,
    output int                         value_errors_o,
    output int                         protocol_errors_o,
    output int                         i_resps_o,
    output int                         d_resps_o
);

    logic [31:0] stored [logic [31:0]];   // data words written so far
    logic        prev_rst    = 1'b1;
    logic        prev_iresp  = 1'b0;
    logic        prev_dresp  = 1'b0;
    logic        prev_strobe = 1'b0;
    logic [31:0] prev_addr   = '0;
    int          beats       = 0;          // resp beats in the current strobe
    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          i_resps = 0;
    int          d_resps = 0;

    assign value_errors_o    = value_errors;
    assign protocol_errors_o = protocol_errors;
    assign i_resps_o         = i_resps;
    assign d_resps_o         = d_resps;

    // initial memory image follows the same rule as the burst memory model
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    task flag_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("** Error at %0d ns: %s expected %h, got %h", $time, sig, exp, act);
        value_errors++;
    endtask

    task flag_protocol(input string what);
        $display("protocol error at %0d ns: %s", $time, what);
        protocol_errors++;
    endtask

    // sampled mid-cycle away from both the DUT edge and the stimulus edge
    always @(negedge clk) begin
        logic [31:0] waddr;
        logic [31:0] exp_word;
        logic        strobe;
        int          b;
        strobe = bmem_read_i || bmem_write_i;
        if (rst || prev_rst) begin
            if (imem_resp_i !== 1'b0 || dmem_resp_i !== 1'b0)
                flag_protocol("a CPU resp is not low during or right after reset");
            if (bmem_read_i !== 1'b0 || bmem_write_i !== 1'b0)
                flag_protocol("a bmem strobe is not low during or right after reset");
        end
        if (!rst && imem_resp_i) begin
            i_resps++;
            if (!imem_req_i.read) flag_protocol("imem resp with no fetch pending");
            if (prev_iresp) flag_protocol("imem resp high for more than one cycle");
            exp_word = fill_word({imem_req_i.addr[31:2], 2'b00});
            if (imem_rdata_i !== exp_word) flag_value("imem_rdata", exp_word, imem_rdata_i);
        end
        if (!rst && dmem_resp_i) begin
            d_resps++;
            if (!(dmem_req_i.read || dmem_req_i.write))
                flag_protocol("dmem resp with no access pending");
            if (prev_dresp) flag_protocol("dmem resp high for more than one cycle");
            waddr    = {dmem_req_i.addr[31:2], 2'b00};
            exp_word = stored.exists(waddr) ? stored[waddr] : fill_word(waddr);
            if (dmem_req_i.write) begin
                for (b = 0; b < 4; b++) begin
                    if (dmem_req_i.wmask[b]) exp_word[8*b +: 8] = dmem_req_i.wdata[8*b +: 8];
                end
                stored[waddr] = exp_word;   // reference follows every accepted store
            end
            if (dmem_rdata_i !== exp_word) flag_value("dmem_rdata", exp_word, dmem_rdata_i);
        end
        if (!rst) begin
            if (bmem_read_i && bmem_write_i)
                flag_protocol("bmem_read and bmem_write are high together");
            if (strobe && bmem_address_i[4:0] != 5'd0)
                flag_value("bmem_address", {bmem_address_i[31:5], 5'd0}, bmem_address_i);
            if (strobe && prev_strobe && bmem_address_i != prev_addr)
                flag_value("bmem_address", prev_addr, bmem_address_i);
            if (strobe && bmem_resp_i) beats++;
            if (prev_strobe && !strobe) begin
                if (beats != 4) flag_value("bmem_resp beat count", 32'd4, beats);
                beats = 0;
            end
        end
        prev_rst    = rst;
        prev_iresp  = imem_resp_i;
        prev_dresp  = dmem_resp_i;
        prev_strobe = strobe;
        prev_addr   = bmem_address_i;
    end

endmodule : mem_checker

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int BEAT_W         = 64;
    localparam int LINE_W         = 256;
    localparam int WORDS_PER_LINE = 8;
    localparam int BEATS_PER_LINE = 4;
    localparam int OFFSET_W       = 5;    // byte offset in a line
    localparam int INDEX_W        = 3;    // 8 sets
    localparam int TAG_W          = 24;

    // one line seen as cpu words or as bus beats
    typedef union packed {
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
        logic [BEATS_PER_LINE-1:0][BEAT_W-1:0] beats;
    } line_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              read;
    } imem_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic                read;
        logic                write;
        logic [WORD_W/8-1:0] wmask;    // one bit per byte lane
        logic [WORD_W-1:0]   wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;     // line aligned
        logic              read;
        logic              write;
        line_t             wdata;
    } line_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } line_rsp_t;

endpackage : mem_pkg

`default_nettype wire

// ==== mem_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_sys (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_pkg::imem_req_t         imem_req_i,
    output logic                       imem_resp_o,
    output logic [mem_pkg::WORD_W-1:0] imem_rdata_o,
    input  mem_pkg::dmem_req_t         dmem_req_i,
    output logic                       dmem_resp_o,
    output logic [mem_pkg::WORD_W-1:0] dmem_rdata_o,
    output logic [mem_pkg::ADDR_W-1:0] bmem_address_o,
    output logic                       bmem_read_o,
    output logic                       bmem_write_o,
    output logic [mem_pkg::BEAT_W-1:0] bmem_wdata_o,
    input  logic [mem_pkg::BEAT_W-1:0] bmem_rdata_i,
    input  logic                       bmem_resp_i
);

    mem_pkg::line_req_t i_line_req;   // icache -> arbiter
    mem_pkg::line_rsp_t i_line_rsp;
    mem_pkg::line_req_t d_line_req;   // dcache -> arbiter
    mem_pkg::line_rsp_t d_line_rsp;
    mem_pkg::line_req_t mem_req;      // arbiter -> adaptor
    mem_pkg::line_rsp_t mem_rsp;

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .imem_req_i   (imem_req_i),
        .imem_resp_o  (imem_resp_o),
        .imem_rdata_o (imem_rdata_o),
        .line_req_o   (i_line_req),
        .line_rsp_i   (i_line_rsp)
    );

    dcache u_dcache (
        .clk          (clk),
        .rst          (rst),
        .dmem_req_i   (dmem_req_i),
        .dmem_resp_o  (dmem_resp_o),
        .dmem_rdata_o (dmem_rdata_o),
        .line_req_o   (d_line_req),
        .line_rsp_i   (d_line_rsp)
    );

    line_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .i_req_i   (i_line_req),
        .d_req_i   (d_line_req),
        .i_rsp_o   (i_line_rsp),
        .d_rsp_o   (d_line_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    line_adaptor u_adaptor (
        .clk            (clk),
        .rst            (rst),
        .line_req_i     (mem_req),
        .line_rsp_o     (mem_rsp),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule : mem_sys

`default_nettype wire

// ==== project.f ====
mem_pkg.sv
icache.sv
dcache.sv
line_arbiter.sv
line_adaptor.sv
mem_sys.sv
mem_checker.sv
tb_mem_sys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_mem_sys \
    -Mdir obj_dir -o sim_mem_sys
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_sys)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// ==== tb_mem_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_sys;

    localparam logic [31:0] MEM_BASE = 32'h0000_4000;   // 8 KB backing store
    localparam logic [31:0] I_BASE   = 32'h0000_4000;   // instruction region
    localparam logic [31:0] D_BASE   = 32'h0000_5000;   // data region
    localparam int          N_REQ    = 300;
    localparam int          TIMEOUT  = 500;

    logic                       clk = 1'b0;
    logic                       rst;
    mem_pkg::imem_req_t         imem_req;
    logic                       imem_resp;
    logic [mem_pkg::WORD_W-1:0] imem_rdata;
    mem_pkg::dmem_req_t         dmem_req;
    logic                       dmem_resp;
    logic [mem_pkg::WORD_W-1:0] dmem_rdata;
    logic [mem_pkg::ADDR_W-1:0] bmem_address;
    logic                       bmem_read;
    logic                       bmem_write;
    logic [mem_pkg::BEAT_W-1:0] bmem_wdata;
    logic [mem_pkg::BEAT_W-1:0] bmem_rdata;
    logic                       bmem_resp;
    logic [63:0]                beat_mem [1024];
    logic [31:0]                i_rng;
    logic [31:0]                d_rng;
    logic [31:0]                m_rng;
    int                         value_errors;
    int                         protocol_errors;
    int                         i_resps;
    int                         d_resps;
    int                         count_errors;

    mem_sys u_dut (
        .clk            (clk),
        .rst            (rst),
        .imem_req_i     (imem_req),
        .imem_resp_o    (imem_resp),
        .imem_rdata_o   (imem_rdata),
        .dmem_req_i     (dmem_req),
        .dmem_resp_o    (dmem_resp),
        .dmem_rdata_o   (dmem_rdata),
        .bmem_address_o (bmem_address),
        .bmem_read_o    (bmem_read),
        .bmem_write_o   (bmem_write),
        .bmem_wdata_o   (bmem_wdata),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_resp_i    (bmem_resp)
    );

    mem_checker u_chk (
        .clk               (clk),
        .rst               (rst),
        .imem_req_i        (imem_req),
        .imem_resp_i       (imem_resp),
        .imem_rdata_i      (imem_rdata),
        .dmem_req_i        (dmem_req),
        .dmem_resp_i       (dmem_resp),
        .dmem_rdata_i      (dmem_rdata),
        .bmem_address_i    (bmem_address),
        .bmem_read_i       (bmem_read),
        .bmem_write_i      (bmem_write),
        .bmem_resp_i       (bmem_resp),
        .value_errors_o    (value_errors),
        .protocol_errors_o (protocol_errors),
        .i_resps_o         (i_resps),
        .d_resps_o         (d_resps)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;   // inputs change well after the edge
    endtask

    task automatic print_counts();
        $display("errors: %0d value, %0d protocol, %0d response count",
                 value_errors, protocol_errors, count_errors);
    endtask

    task automatic abort_on_hang(input string what);
        $display("timeout: no %s response within %0d cycles, the memory system hangs",
                 what, TIMEOUT);
        print_counts();
        $display("Test failed");
        $finish;
    endtask

    task automatic wait_resp(input bit data_side, input string what);
        int t;
        t = 0;
        next_cycle();
        while (!(data_side ? dmem_resp : imem_resp) && t < TIMEOUT) begin
            next_cycle();
            t++;
        end
        if (!(data_side ? dmem_resp : imem_resp)) abort_on_hang(what);
    endtask

    task automatic run_fetches();
        int          n;
        logic [31:0] r;
        for (n = 0; n < N_REQ; n++) begin
            i_rng         = xorshift32(i_rng);
            r             = i_rng;
            imem_req.addr = I_BASE + {20'd0, r[11:2], 2'b00};
            imem_req.read = 1'b1;
            wait_resp(1'b0, "instruction fetch");
            next_cycle();                    // hold through the resp cycle
            imem_req.read = 1'b0;
            repeat (r[13:12]) next_cycle();
        end
    endtask

    task automatic run_data_traffic();
        int          n;
        logic [31:0] r;
        for (n = 0; n < N_REQ; n++) begin
            d_rng          = xorshift32(d_rng);
            r              = d_rng;
            // four tags per set, so misses hit dirty victims often
            dmem_req.addr  = D_BASE + {20'd0, r[13:12], 2'b00, r[7:2], 2'b00};
            dmem_req.write = r[16];
            dmem_req.read  = !r[16];
            dmem_req.wmask = r[20:17];
            d_rng          = xorshift32(d_rng);
            dmem_req.wdata = d_rng;
            wait_resp(1'b1, "data access");
            next_cycle();
            dmem_req.read  = 1'b0;
            dmem_req.write = 1'b0;
            repeat (r[25:24]) next_cycle();
        end
    endtask

    initial begin
        forever #50 clk = ~clk;
    end

    // burst memory with 0 to 3 idle cycles before each beat
    initial begin : burst_memory
        logic [1:0]  wait_cnt;
        logic [2:0]  beat;
        logic [9:0]  idx;
        logic [31:0] offs;
        logic [31:0] a;
        int          i;
        bmem_resp  = 1'b0;
        bmem_rdata = '0;
        m_rng      = 32'h6db8fc7e ^ 32'h7f4a_7c15;
        wait_cnt   = 2'd0;
        beat       = 3'd0;
        for (i = 0; i < 1024; i++) begin
            a           = MEM_BASE + (i << 3);
            beat_mem[i] = {fill_word(a + 32'd4), fill_word(a)};
        end
        forever begin
            next_cycle();
            bmem_resp = 1'b0;
            if (!(bmem_read || bmem_write)) begin
                beat     = 3'd0;
                m_rng    = xorshift32(m_rng);
                wait_cnt = m_rng[1:0];
            end else if (wait_cnt != 2'd0) begin
                wait_cnt = wait_cnt - 2'd1;
            end else if (beat < 3'd4) begin
                offs = bmem_address - MEM_BASE;
                idx  = offs[12:3] + {7'd0, beat};
                if (bmem_write) beat_mem[idx] = bmem_wdata;
                else bmem_rdata = beat_mem[idx];
                bmem_resp = 1'b1;
                beat      = beat + 3'd1;
                m_rng     = xorshift32(m_rng);
                wait_cnt  = m_rng[1:0];
            end
        end
    end

    initial begin : main
        rst          = 1'b1;
        imem_req     = '0;
        dmem_req     = '0;
        count_errors = 0;
        i_rng        = 32'h6db8fc7e;
        d_rng        = 32'h6db8fc7e ^ 32'h9e37_79b9;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        fork
            run_fetches();
            run_data_traffic();
        join
        repeat (4) next_cycle();
        if (i_resps != N_REQ) begin
            $display("imem answered %0d fetches but %0d were issued", i_resps, N_REQ);
            count_errors++;
        end
        if (d_resps != N_REQ) begin
            $display("dmem answered %0d accesses but %0d were issued", d_resps, N_REQ);
            count_errors++;
        end
        print_counts();
        if (value_errors + protocol_errors + count_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_mem_sys

`default_nettype wire
